//--- vlog.f
+incdir+include
hdl/axilwb_pkg.sv
hdl/axil_ar_issue.sv
hdl/wb_ack_tracker.sv
hdl/rd_resp_buffer.sv
hdl/axilrd2wbsp.sv
sim/tb_clkgen.sv
sim/wb_slave_model.sv
sim/axilrd2wbsp_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module axilrd2wbsp_tb \
	-f vlog.f -o axilrd2wbsp_sim

# The simulator may exit nonzero on failure, the log decides the verdict
./obj_dir/axilrd2wbsp_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
	echo "Simulation ended without a verdict"
	exit 1
fi
echo "Simulation passed"

//--- sim/axilrd2wbsp_tb.sv
`timescale 1ns/1ps
`include "axilwb_macros.svh"

module axilrd2wbsp_tb;

	// 55 reads at about 60 cycles each in the worst case plus margin
	localparam int max_cycles = 4000;

	logic                  clk;
	logic                  reset_n;
	logic                  arvalid = 1'b0;
	logic [`AXILWB_AW-1:0] araddr = '0;
	logic                  arready;
	logic                  rvalid;
	logic                  rready = 1'b1;
	axilwb_pkg::rd_beat_t  r_beat;
	logic                  wb_cyc;
	logic                  wb_stb;
	logic                  wb_stall;
	logic [`AXILWB_AW-3:0] wb_addr;
	axilwb_pkg::wb_rsp_t   wb_rsp;

	logic [15:0]           lfsr = 16'd16013;
	logic                  stall_rand = 1'b0;
	logic [1:0]            delay_rand = 2'd0;
	logic [`AXILWB_AW-3:0] err_addr = '0;
	logic                  err_en = 1'b0;
	int                    rready_mode = 0;
	string                 test_name = "reset state";
	logic [31:0]           exp_data [$];
	logic [1:0]            exp_resp [$];
	logic                  err_req_accepted = 1'b0;
	logic                  err_done = 1'b0;
	int                    cycles = 0;
	int                    beats = 0;
	int                    bus_errs = 0;

	tb_clkgen u_clkgen (.o_clk(clk), .o_reset_n(reset_n));

	wb_slave_model u_slave
	(
		.i_clk (clk), .i_wb_cyc (wb_cyc), .i_wb_stb (wb_stb), .i_wb_addr (wb_addr),
		.i_stall_rand (stall_rand), .i_delay_rand (delay_rand),
		.i_err_addr (err_addr), .i_err_en (err_en),
		.o_wb_stall (wb_stall), .o_wb_rsp (wb_rsp)
	);

	axilrd2wbsp UUT
	(
		.i_clk (clk), .i_axi_reset_n (reset_n),
		.i_axi_arvalid (arvalid), .i_axi_araddr (araddr), .o_axi_arready (arready),
		.o_axi_rvalid (rvalid), .o_axi_r (r_beat), .i_axi_rready (rready),
		.o_wb_cyc (wb_cyc), .o_wb_stb (wb_stb), .o_wb_addr (wb_addr),
		.i_wb_stall (wb_stall), .i_wb_rsp (wb_rsp)
	);

	//////////////////////////////////////////////////
	// Random bits and checking helpers
	//////////////////////////////////////////////////

	// Galois form with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_bit(output logic b);
		b    = lfsr[0];
		lfsr = lfsr_next(lfsr);
	endtask

	// Slave data rule puts the word address under an A5 top byte
	function automatic logic [31:0] expected_data(input logic [`AXILWB_AW-1:0] addr);
		return {8'hA5, addr[25:2]};
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("Mismatch in %s, %s: expected %h, actual %h",
				test_name, what, expected, actual);
			$display("Simulation finished: FAIL");
			$fatal(1, "check failed");
		end
	endtask

	always @(posedge clk)
	begin
		logic b0;
		logic b1;
		logic b2;
		logic b3;
		logic b4;
		int   mode;
		mode = rready_mode;
		#1;
		take_bit(b0);
		take_bit(b1);
		take_bit(b2);
		take_bit(b3);
		take_bit(b4);
		stall_rand = b0 & b1;
		delay_rand = {b2, b3};
		rready     = (mode == 0) ? 1'b1 : ((mode == 1) ? b4 : 1'b0);
	end

	//////////////////////////////////////////////////
	// Scoreboard and timeout
	//////////////////////////////////////////////////

	always @(posedge clk)
	begin
		logic [1:0] resp;
		cycles++;
		if (cycles >= max_cycles)
		begin
			$display("Timeout: the run did not finish within %0d cycles", max_cycles);
			$display("Simulation finished: FAIL");
			$fatal(1, "timeout");
		end
		// No new address while the error backlog drains
		if (err_done)
			check_value("arready during error hold", 32'd0, {31'd0, arready});
		if (reset_n && arvalid && arready)
		begin
			if (err_en && (araddr[`AXILWB_AW-1:2] == err_addr))
			begin
				resp             = axilwb_pkg::RESP_SLVERR;
				err_req_accepted = 1'b1;
			end
			else if (err_req_accepted && !err_done)
				resp = axilwb_pkg::RESP_DECERR;
			else
				resp = axilwb_pkg::RESP_OKAY;
			exp_data.push_back(expected_data(araddr));
			exp_resp.push_back(resp);
		end
		if (reset_n && rvalid && rready)
		begin
			if (exp_data.size() == 0)
			begin
				$display("Error in %s: an R beat arrived with no read outstanding", test_name);
				$display("Simulation finished: FAIL");
				$fatal(1, "unexpected beat");
			end
			else
			begin
				check_value("rresp", {30'd0, exp_resp[0]}, {30'd0, r_beat.resp});
				if (exp_resp[0] == axilwb_pkg::RESP_OKAY)
					check_value("rdata", exp_data[0], r_beat.data);
				void'(exp_data.pop_front());
				void'(exp_resp.pop_front());
				beats++;
				if (err_done && exp_data.size() == 0)
				begin
					err_done         = 1'b0;
					err_req_accepted = 1'b0;
				end
			end
		end
		if (wb_cyc && wb_rsp.err)
		begin
			err_done = 1'b1;
			bus_errs++;
		end
	end

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic issue_read(input logic [`AXILWB_AW-1:0] addr);
		arvalid = 1'b1;
		araddr  = addr;
		@(posedge clk);
		while (!arready)
			@(posedge clk);
		#1;
		arvalid = 1'b0;
	endtask

	task automatic wait_drain;
		do
		begin
			@(posedge clk);
			#1;
		end
		while (exp_data.size() != 0);
	endtask

	task automatic check_reset_state;
		test_name = "reset state";
		check_value("cyc", 32'd0, {31'd0, wb_cyc});
		check_value("stb", 32'd0, {31'd0, wb_stb});
		check_value("rvalid", 32'd0, {31'd0, rvalid});
		check_value("arready", 32'd1, {31'd0, arready});
	endtask

	task automatic stream_reads(input string name, input int n, input logic [27:0] base);
		test_name = name;
		for (int i = 0; i < n; i++)
			issue_read(base + 28'(i * 4));
		wait_drain();
	endtask

	task automatic fill_under_backpressure;
		test_name   = "back-pressure";
		rready_mode = 2;
		for (int i = 0; i < 8; i++)
			issue_read(28'h0200000 + 28'(i * 4));
		@(posedge clk);
		check_value("arready with buffer full", 32'd0, {31'd0, arready});
		#1;
		rready_mode = 1;
		for (int i = 8; i < 20; i++)
			issue_read(28'h0200000 + 28'(i * 4));
		wait_drain();
		rready_mode = 0;
	endtask

	task automatic read_through_bus_error;
		test_name = "bus error";
		bus_errs  = 0;
		err_addr  = 26'h0C0002;
		err_en    = 1'b1;
		for (int i = 0; i < 6; i++)
			issue_read(28'h0300000 + 28'(i * 4));
		wait_drain();
		check_value("bus error count", 32'd1, bus_errs);
		err_en = 1'b0;
	endtask

	initial
	begin
		wait (reset_n);
		@(posedge clk);
		#1;
		check_reset_state();
		stream_reads("single read", 1, 28'h0000100);
		stream_reads("streamed reads", 20, 28'h0010000);
		fill_under_backpressure();
		read_through_bus_error();
		stream_reads("recovery", 8, 28'h0400000);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- sim/wb_slave_model.sv
`timescale 1ns/1ps
`include "axilwb_macros.svh"

module wb_slave_model
(
	input  logic                  i_clk,
	input  logic                  i_wb_cyc,
	input  logic                  i_wb_stb,
	input  logic [`AXILWB_AW-3:0] i_wb_addr,
	input  logic                  i_stall_rand,
	input  logic [1:0]            i_delay_rand,
	input  logic [`AXILWB_AW-3:0] i_err_addr,
	input  logic                  i_err_en,
	output logic                  o_wb_stall,
	output axilwb_pkg::wb_rsp_t   o_wb_rsp
);

	// Requests taken but not yet answered, oldest first
	logic [`AXILWB_AW-3:0] q_addr [$];
	int                    q_wait [$];

	initial
	begin
		o_wb_stall = 1'b0;
		o_wb_rsp   = '0;
	end

	always @(posedge i_clk)
	begin
		logic       stall_next;
		logic [1:0] delay_next;
		stall_next = i_stall_rand;
		delay_next = i_delay_rand;
		if (!i_wb_cyc)
		begin
			// Cycle dropped, anything pending is abandoned
			q_addr.delete();
			q_wait.delete();
		end
		else
		begin
			if (o_wb_rsp.ack || o_wb_rsp.err)
			begin
				void'(q_addr.pop_front());
				void'(q_wait.pop_front());
			end
			if (i_wb_stb && !o_wb_stall)
			begin
				q_addr.push_back(i_wb_addr);
				q_wait.push_back(int'(delay_next));
			end
		end
		#1;
		o_wb_stall = stall_next;
		o_wb_rsp   = '0;
		if (q_addr.size() != 0)
		begin
			if (q_wait[0] == 0)
			begin
				o_wb_rsp.err  = i_err_en && (q_addr[0] == i_err_addr);
				o_wb_rsp.ack  = !o_wb_rsp.err;
				o_wb_rsp.data = {8'hA5, q_addr[0][23:0]};
			end
			else
				q_wait[0] = q_wait[0] - 1;
		end
	end

endmodule

//--- sim/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen
(
	output logic o_clk,
	output logic o_reset_n
);

	// 20 ns period
	initial
	begin
		o_clk = 1'b0;
		forever #10 o_clk = ~o_clk;
	end

	// Reset held for 4 cycles, released just after an edge
	initial
	begin
		o_reset_n = 1'b0;
		repeat (4) @(posedge o_clk);
		#1 o_reset_n = 1'b1;
	end

endmodule

//--- hdl/axilrd2wbsp.sv
`timescale 1ns/1ps
`include "axilwb_macros.svh"

module axilrd2wbsp
(
	input  logic                  i_clk,
	input  logic                  i_axi_reset_n,
	// AXI read address channel
	input  logic                  i_axi_arvalid,
	input  logic [`AXILWB_AW-1:0] i_axi_araddr,
	output logic                  o_axi_arready,
	// AXI read data channel
	output logic                  o_axi_rvalid,
	output axilwb_pkg::rd_beat_t  o_axi_r,
	input  logic                  i_axi_rready,
	// Wishbone master
	output logic                  o_wb_cyc,
	output logic                  o_wb_stb,
	output logic [`AXILWB_AW-3:0] o_wb_addr,
	input  logic                  i_wb_stall,
	input  axilwb_pkg::wb_rsp_t   i_wb_rsp
);

	logic w_reset;
	logic accept;
	logic wb_err_seen;
	logic full;
	logic err_hold;
	logic returned;

	assign w_reset = !i_axi_reset_n;

	//////////////////////////////////////////////////
	// Address issue, ack tracking, response buffer
	//////////////////////////////////////////////////

	axil_ar_issue u_issue
	(
		.i_clk         (i_clk),
		.i_reset       (w_reset),
		.i_axi_arvalid (i_axi_arvalid),
		.i_axi_araddr  (i_axi_araddr),
		.o_axi_arready (o_axi_arready),
		.o_accept      (accept),
		.i_wb_stall    (i_wb_stall),
		.i_wb_err_seen (wb_err_seen),
		.i_full        (full),
		.i_err_hold    (err_hold),
		.o_wb_stb      (o_wb_stb),
		.o_wb_addr     (o_wb_addr)
	);

	wb_ack_tracker u_tracker
	(
		.i_clk         (i_clk),
		.i_reset       (w_reset),
		.i_wb_stb      (o_wb_stb),
		.i_wb_stall    (i_wb_stall),
		.i_wb_rsp      (i_wb_rsp),
		.i_err_hold    (err_hold),
		.o_wb_cyc      (o_wb_cyc),
		.o_returned    (returned),
		.o_wb_err_seen (wb_err_seen)
	);

	rd_resp_buffer u_buffer
	(
		.i_clk        (i_clk),
		.i_reset      (w_reset),
		.i_accept     (accept),
		.i_returned   (returned),
		.i_wb_rsp     (i_wb_rsp),
		.o_full       (full),
		.o_err_hold   (err_hold),
		.o_axi_rvalid (o_axi_rvalid),
		.o_axi_r      (o_axi_r),
		.i_axi_rready (i_axi_rready)
	);

endmodule

//--- hdl/rd_resp_buffer.sv
`timescale 1ns/1ps
`include "axilwb_macros.svh"

module rd_resp_buffer
(
	input  logic                 i_clk,
	input  logic                 i_reset,
	input  logic                 i_accept,
	input  logic                 i_returned,
	input  axilwb_pkg::wb_rsp_t  i_wb_rsp,
	output logic                 o_full,
	output logic                 o_err_hold,
	// AXI read data channel
	output logic                 o_axi_rvalid,
	output axilwb_pkg::rd_beat_t o_axi_r,
	input  logic                 i_axi_rready
);

	localparam int lgfifo = `AXILWB_LGFIFO;
	localparam int depth  = 1 << lgfifo;

	logic [`AXILWB_DW-1:0] dfifo [0:depth-1];

	// first: accepted, mid: answered by the bus, last: read out
	logic [lgfifo:0] r_first;
	logic [lgfifo:0] r_mid;
	logic [lgfifo:0] r_last;
	logic [lgfifo:0] err_loc;

	logic [lgfifo:0] next_last;
	logic [lgfifo:0] fill;
	logic [lgfifo:0] show_slot;
	logic [lgfifo:0] err_slot;
	logic [lgfifo:0] err_dist;
	logic            read_beat;
	logic            err_now;
	logic            resp_hold;

	axilwb_pkg::rresp_e r_resp;
	axilwb_pkg::rresp_e next_resp;

	assign read_beat = o_axi_rvalid && i_axi_rready;
	assign err_now   = i_returned && i_wb_rsp.err;
	assign next_last = r_last + 1'b1;
	assign fill      = r_first - r_last;

	// Fill never exceeds the depth, so the top bit alone marks full
	assign o_full = fill[lgfifo];

	//////////////////////////////////////////////////
	// Pointers
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			r_first <= '0;
			r_mid   <= '0;
			r_last  <= '0;
		end
		else
		begin
			if (i_accept)
				r_first <= r_first + 1'b1;
			// Unissued slots are skipped over during the error hold
			if (i_returned || (o_err_hold && (r_mid != r_first)))
				r_mid <= r_mid + 1'b1;
			if (read_beat)
				r_last <= next_last;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_returned)
			dfifo[r_mid[lgfifo-1:0]] <= i_wb_rsp.data;
		if (err_now)
			err_loc <= r_mid;
	end

	// Hold lasts until every accepted request has been answered
	always_ff @(posedge i_clk)
	begin
		if (i_reset || (r_first == r_last))
			o_err_hold <= 1'b0;
		else if (err_now)
			o_err_hold <= 1'b1;
	end

	//////////////////////////////////////////////////
	// Response code for the next beat shown
	//////////////////////////////////////////////////

	assign show_slot = read_beat ? next_last : r_last;
	assign resp_hold = o_err_hold || err_now;
	assign err_slot  = o_err_hold ? err_loc : r_mid;
	assign err_dist  = show_slot - err_slot;

	always_comb
	begin
		if (!resp_hold)
			next_resp = axilwb_pkg::RESP_OKAY;
		else if (err_dist == '0)
			next_resp = axilwb_pkg::RESP_SLVERR;
		else if (!err_dist[lgfifo])
			next_resp = axilwb_pkg::RESP_DECERR;
		else
			next_resp = axilwb_pkg::RESP_OKAY; // slot ahead of the error
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			r_resp <= axilwb_pkg::RESP_OKAY;
		else if (!o_axi_rvalid || i_axi_rready)
			r_resp <= next_resp;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_axi_rvalid <= 1'b0;
		else if (i_returned)
			o_axi_rvalid <= 1'b1;
		else if (read_beat)
			o_axi_rvalid <= o_err_hold ? (next_last != r_first) : (next_last != r_mid);
	end

	assign o_axi_r = '{data: dfifo[r_last[lgfifo-1:0]], resp: r_resp};

endmodule

//--- hdl/wb_ack_tracker.sv
`timescale 1ns/1ps
`include "axilwb_macros.svh"

module wb_ack_tracker
(
	input  logic                i_clk,
	input  logic                i_reset,
	input  logic                i_wb_stb,
	input  logic                i_wb_stall,
	input  axilwb_pkg::wb_rsp_t i_wb_rsp,
	input  logic                i_err_hold,
	output logic                o_wb_cyc,
	output logic                o_returned,
	output logic                o_wb_err_seen
);

	localparam int lgfifo = `AXILWB_LGFIFO;

	// Requests issued but not yet answered, at most the buffer depth
	logic [lgfifo:0] outstanding;
	logic            issue;

	assign issue = i_wb_stb && !i_wb_stall;

	assign o_wb_cyc = i_wb_stb || (outstanding != '0);

	// Responses only count while the cycle is open
	assign o_returned    = o_wb_cyc && (i_wb_rsp.ack || i_wb_rsp.err);
	assign o_wb_err_seen = o_wb_cyc && i_wb_rsp.err;

	//////////////////////////////////////////////////
	// Outstanding count
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset || o_wb_err_seen || i_err_hold || !o_wb_cyc)
		begin
			// An error abandons the cycle and anything still in flight
			outstanding <= '0;
		end
		else
		begin
			case ({issue, i_wb_rsp.ack})
				2'b10: outstanding <= outstanding + 1'b1;
				2'b01: outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;
			endcase
		end
	end

endmodule

//--- hdl/axil_ar_issue.sv
`timescale 1ns/1ps
`include "axilwb_macros.svh"

module axil_ar_issue
(
	input  logic                  i_clk,
	input  logic                  i_reset,
	// AXI read address channel
	input  logic                  i_axi_arvalid,
	input  logic [`AXILWB_AW-1:0] i_axi_araddr,
	output logic                  o_axi_arready,
	output logic                  o_accept,
	// Bus and buffer status
	input  logic                  i_wb_stall,
	input  logic                  i_wb_err_seen,
	input  logic                  i_full,
	input  logic                  i_err_hold,
	// Wishbone request
	output logic                  o_wb_stb,
	output logic [`AXILWB_AW-3:0] o_wb_addr
);

	// Room in the buffer, no error backlog, and the strobe slot is free
	// or about to be
	assign o_axi_arready = !i_full && !i_err_hold && (!o_wb_stb || !i_wb_stall);

	assign o_accept = i_axi_arvalid && o_axi_arready;

	//////////////////////////////////////////////////
	// Strobe
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset || i_wb_err_seen || i_err_hold)
		begin
			// Bus error kills any pending strobe
			o_wb_stb <= 1'b0;
		end
		else if (o_accept)
		begin
			o_wb_stb <= 1'b1;
		end
		else if (!i_wb_stall)
		begin
			o_wb_stb <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// Word address
	//////////////////////////////////////////////////

	// Loaded whenever arready is high so issues can go back to back
	always_ff @(posedge i_clk)
	begin
		if (o_axi_arready)
		begin
			o_wb_addr <= i_axi_araddr[`AXILWB_AW-1:2];
		end
	end

endmodule

//--- hdl/axilwb_pkg.sv
`include "axilwb_macros.svh"

package axilwb_pkg;

	// AXI read response codes
	typedef enum logic [1:0]
	{
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} rresp_e;

	// Wishbone return path, sampled while cyc is high
	typedef struct packed
	{
		logic                  ack;
		logic                  err;
		logic [`AXILWB_DW-1:0] data;
	} wb_rsp_t;

	// One AXI R channel beat
	typedef struct packed
	{
		logic [`AXILWB_DW-1:0] data;
		rresp_e                resp;
	} rd_beat_t;

endpackage

//--- include/axilwb_macros.svh
`ifndef AXILWB_MACROS_SVH
`define AXILWB_MACROS_SVH

//////////////////////////////////////////////////
// Bridge widths
//////////////////////////////////////////////////

// AXI byte address width
`define AXILWB_AW 28

// Data width on both buses
`define AXILWB_DW 32

// Log2 of the response buffer depth
`define AXILWB_LGFIFO 3

`endif
